/* hdl/dtim.sv */
`default_nettype none
`timescale 1ns/1ns

module dtim import lsuPkg::*; #(
  parameter int DTIM_ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      memReadEn,
  input  logic                      memWriteEn,
  input  logic [DTIM_ADDR_BITS-3:0] memAdr,       // Word address
  input  logic [XLEN-1:0]           memWriteData,
  input  logic [XBYTES-1:0]         memByteMask,  // One enable per lane
  output logic [XLEN-1:0]           memReadData
);

  localparam int DEPTH = 2 ** (DTIM_ADDR_BITS - 2);

  logic [XLEN-1:0] ram [DEPTH];

  ////////////////////////////////////////////////////////////
  // Byte-enable write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (memWriteEn) begin
      for (int i = 0; i < XBYTES; i++) begin
        if (memByteMask[i]) begin
          ram[memAdr][8*i +: 8] <= memWriteData[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered read, holds until next read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (memReadEn) begin
      memReadData <= ram[memAdr];  // Valid the cycle after the enable
    end
  end

endmodule

`default_nettype wire

/* hdl/loadFormat.sv */
`default_nettype none
`timescale 1ns/1ns

module loadFormat import lsuPkg::*; (
  input  logic [XLEN-1:0] memReadData,    // Raw DTIM word
  input  sizeT            mSize,
  input  logic [1:0]      mAdr,           // Byte offset within word
  input  logic            mBigEndian,
  output logic [XLEN-1:0] loadData
);

  logic [XLEN-1:0] leWord;                // Word in little-endian order
  logic [7:0]      byteVal;
  logic [15:0]     halfVal;

  ////////////////////////////////////////////////////////////
  // Swap, then pick the addressed lanes
  ////////////////////////////////////////////////////////////

  assign leWord  = mBigEndian ? byteSwap(memReadData) : memReadData;
  assign byteVal = leWord[{mAdr, 3'b000} +: 8];
  assign halfVal = leWord[{mAdr[1], 4'b0000} +: 16];   // Bit 0 ignored, aligned only

  // Sign or zero extension per funct3 size
  always_comb begin
    case (mSize)
      sizeByte: begin
        loadData = {{(XLEN-8){byteVal[7]}}, byteVal};
      end
      sizeByteU: begin
        loadData = {{(XLEN-8){1'b0}}, byteVal};
      end
      sizeHalf: begin
        loadData = {{(XLEN-16){halfVal[15]}}, halfVal};
      end
      sizeHalfU: begin
        loadData = {{(XLEN-16){1'b0}}, halfVal};
      end
      default: begin
        loadData = leWord;                // Word load
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu.sv */
`default_nettype none
`timescale 1ns/1ns

module lsu import lsuPkg::*; #(
  parameter int DTIM_ADDR_BITS = 10           // Byte address bits of the DTIM
) (
  input  logic            clk,
  input  logic            reset,
  // Request port
  input  logic            reqValid,
  output logic            reqReady,
  input  memOpT           reqOp,
  input  sizeT            reqSize,
  input  logic [XLEN-1:0] reqAdr,
  input  logic [XLEN-1:0] reqWriteData,
  input  logic            reqBigEndian,
  // Response port
  output logic            respValid,
  input  logic            respReady,
  output logic [XLEN-1:0] respReadData,
  output logic            respLoadMisaligned,
  output logic            respStoreMisaligned,
  output logic            respScFail
);

  logic                      memReadEn, memWriteEn;
  logic [DTIM_ADDR_BITS-3:0] memAdr;        // Word address into the DTIM
  logic [XLEN-1:0]           memWriteData;
  logic [XBYTES-1:0]         memByteMask;
  logic [XLEN-1:0]           memReadData;
  logic [XLEN-1:0]           loadData;      // Extended load value for W
  memOpT                     mOp;
  sizeT                      mSize;
  logic [DTIM_ADDR_BITS-1:0] mAdr;
  logic [XLEN-1:0]           mWriteData;
  logic                      mBigEndian, mFire, misaligned, scPermit;

  lsuPipeline #(.DTIM_ADDR_BITS(DTIM_ADDR_BITS)) pipe (
    .clk, .reset, .reqValid, .reqReady, .reqOp, .reqSize, .reqAdr, .reqWriteData,
    .reqBigEndian, .respValid, .respReady, .respReadData, .respLoadMisaligned,
    .respStoreMisaligned, .respScFail, .scPermit, .loadData, .memReadEn, .memAdr,
    .memWriteEn, .mOp, .mSize, .mAdr, .mWriteData, .mBigEndian, .mFire, .misaligned
  );

  reservation #(.DTIM_ADDR_BITS(DTIM_ADDR_BITS)) resv (
    .clk, .reset, .mFire, .mOp, .mAdr, .misaligned, .scPermit
  );

  storeFormat stFmt (
    .mSize, .mAdr(mAdr[1:0]), .mWriteData, .mBigEndian, .memWriteData, .memByteMask
  );

  loadFormat ldFmt (
    .memReadData, .mSize, .mAdr(mAdr[1:0]), .mBigEndian, .loadData
  );

  dtim #(.DTIM_ADDR_BITS(DTIM_ADDR_BITS)) mem (
    .clk, .memReadEn, .memWriteEn, .memAdr, .memWriteData, .memByteMask, .memReadData
  );

endmodule

`default_nettype wire

/* hdl/lsuPipeline.sv */
`default_nettype none
`timescale 1ns/1ns

module lsuPipeline import lsuPkg::*; #(
  parameter int DTIM_ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      reqValid,
  output logic                      reqReady,
  input  memOpT                     reqOp,
  input  sizeT                      reqSize,
  input  logic [XLEN-1:0]           reqAdr,        // Upper bits beyond DTIM ignored
  input  logic [XLEN-1:0]           reqWriteData,
  input  logic                      reqBigEndian,
  output logic                      respValid,
  input  logic                      respReady,
  output logic [XLEN-1:0]           respReadData,
  output logic                      respLoadMisaligned,
  output logic                      respStoreMisaligned,
  output logic                      respScFail,
  input  logic                      scPermit,      // From reservation
  input  logic [XLEN-1:0]           loadData,      // From loadFormat
  output logic                      memReadEn,
  output logic [DTIM_ADDR_BITS-3:0] memAdr,
  output logic                      memWriteEn,
  output memOpT                     mOp,
  output sizeT                      mSize,
  output logic [DTIM_ADDR_BITS-1:0] mAdr,
  output logic [XLEN-1:0]           mWriteData,
  output logic                      mBigEndian,
  output logic                      mFire,         // M moves into W this cycle
  output logic                      misaligned     // M access misaligned
);

  logic mValid;
  logic reqAccept;
  logic mIsLoad;   // Load or LR in M
  logic mWrites;   // M op would write if aligned

  ////////////////////////////////////////////////////////////
  // Handshake and stage control
  ////////////////////////////////////////////////////////////

  assign mFire     = mValid & (~respValid | respReady);   // W free or draining
  assign reqReady  = (~mValid | mFire) & ~memWriteEn;      // DTIM port busy on write
  assign reqAccept = reqValid & reqReady;

  assign memReadEn = reqAccept & (reqOp == opLoad || reqOp == opLr); // Read in E
  assign mIsLoad   = (mOp == opLoad) || (mOp == opLr);
  assign mWrites   = (mOp == opStore) || (mOp == opSc && scPermit);
  assign memWriteEn = mFire & mWrites & ~misaligned;       // Write once as M leaves

  // Write uses the M address, otherwise the incoming E address
  assign memAdr = memWriteEn ? mAdr[DTIM_ADDR_BITS-1:2] : reqAdr[DTIM_ADDR_BITS-1:2];

  // Halfword on odd byte, word off a 4-byte boundary
  always_comb begin
    case (mSize)
      sizeHalf, sizeHalfU: misaligned = mAdr[0];
      sizeWord:            misaligned = |mAdr[1:0];
      default:             misaligned = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // M stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mValid <= 1'b0;
    end else if (reqAccept) begin
      mValid <= 1'b1;
    end else if (mFire) begin
      mValid <= 1'b0;                                      // Drained with nothing behind
    end
  end

  always_ff @(posedge clk) begin
    if (reqAccept) begin
      mOp        <= reqOp;
      mSize      <= reqSize;
      mAdr       <= reqAdr[DTIM_ADDR_BITS-1:0];
      mWriteData <= reqWriteData;
      mBigEndian <= reqBigEndian;
    end
  end

  ////////////////////////////////////////////////////////////
  // W stage register, drives the response port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      respValid <= 1'b0;
    end else if (mFire) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;                                   // Consumed, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (mFire) begin
      respReadData        <= (mIsLoad && !misaligned) ? loadData : '0;
      respLoadMisaligned  <= misaligned & mIsLoad;
      respStoreMisaligned <= misaligned & ~mIsLoad;        // Store and SC side
      respScFail          <= (mOp == opSc) & ~scPermit;
    end
  end

  // Response must not change while the consumer stalls
  respHoldA: assert property (@(posedge clk) disable iff (reset)
    respValid && !respReady |=> respValid && $stable(respReadData) &&
      $stable({respLoadMisaligned, respStoreMisaligned, respScFail}));

  // Single DTIM port, never read and write together
  portExclA: assert property (@(posedge clk) disable iff (reset)
    !(memWriteEn && memReadEn));

endmodule

`default_nettype wire

/* hdl/lsuPkg.sv */
`default_nettype none

package lsuPkg;

  ////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN   = 32;       // Data word width
  localparam int XBYTES = XLEN / 8; // Byte lanes per word

  localparam int MEM_OP_BITS = 2;   // Opcode field width
  localparam int SIZE_BITS   = 3;   // Size field width, funct3 style

  ////////////////////////////////////////////////////////////
  // Request encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [MEM_OP_BITS-1:0] {
    opLoad  = 2'b00,
    opStore = 2'b01,
    opLr    = 2'b10,  // Load reserved
    opSc    = 2'b11   // Store conditional
  } memOpT;

  // Bit 2 set means zero extension on loads
  typedef enum logic [SIZE_BITS-1:0] {
    sizeByte  = 3'b000,
    sizeHalf  = 3'b001,
    sizeWord  = 3'b010,
    sizeByteU = 3'b100,
    sizeHalfU = 3'b101
  } sizeT;

  // Reverse byte order of a word, shared by the load and store swappers
  function automatic logic [XLEN-1:0] byteSwap(input logic [XLEN-1:0] w);
    logic [XLEN-1:0] y;
    for (int i = 0; i < XBYTES; i++) begin
      y[8*i +: 8] = w[8*(XBYTES-1-i) +: 8]; // Lane i takes mirrored lane
    end
    return y;
  endfunction

endpackage

`default_nettype wire

/* hdl/reservation.sv */
`default_nettype none
`timescale 1ns/1ns

module reservation import lsuPkg::*; #(
  parameter int DTIM_ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      mFire,      // M stage retires this edge
  input  memOpT                     mOp,
  input  logic [DTIM_ADDR_BITS-1:0] mAdr,
  input  logic                      misaligned,
  output logic                      scPermit    // SC may write
);

  logic                      resValid;
  logic [DTIM_ADDR_BITS-3:0] resAdr;            // Reserved word address

  ////////////////////////////////////////////////////////////
  // Single reservation, set by LR and cleared by any SC
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (mFire && !misaligned) begin
      if (mOp == opLr) begin
        resValid <= 1'b1;
      end else if (mOp == opSc) begin
        resValid <= 1'b0;                       // Pass or fail
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mFire && !misaligned && mOp == opLr) begin
      resAdr <= mAdr[DTIM_ADDR_BITS-1:2];
    end
  end

  // Word match only, byte offset within word is irrelevant
  assign scPermit = (mOp == opSc) & ~misaligned & resValid &
                    (resAdr == mAdr[DTIM_ADDR_BITS-1:2]);

  scNeedsResA: assert property (@(posedge clk) disable iff (reset)
    scPermit |-> resValid);

endmodule

`default_nettype wire

/* hdl/storeFormat.sv */
`default_nettype none
`timescale 1ns/1ns

module storeFormat import lsuPkg::*; (
  input  sizeT              mSize,
  input  logic [1:0]        mAdr,          // Byte offset within word
  input  logic [XLEN-1:0]   mWriteData,
  input  logic              mBigEndian,
  output logic [XLEN-1:0]   memWriteData,
  output logic [XBYTES-1:0] memByteMask
);

  logic [XLEN-1:0]   leData;              // Little-endian lane data
  logic [XBYTES-1:0] leMask;              // Little-endian lane mask

  ////////////////////////////////////////////////////////////
  // Lane replication and mask
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (mSize)
      sizeByte, sizeByteU: begin
        leData = {XBYTES{mWriteData[7:0]}};                 // Byte into every lane
        leMask = {{(XBYTES-1){1'b0}}, 1'b1} << mAdr;
      end
      sizeHalf, sizeHalfU: begin
        leData = {(XBYTES/2){mWriteData[15:0]}};
        leMask = {{(XBYTES-2){1'b0}}, 2'b11} << {mAdr[1], 1'b0}; // Lower or upper half
      end
      default: begin
        leData = mWriteData;              // Full word
        leMask = '1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Big-endian swap of data and mask
  ////////////////////////////////////////////////////////////

  always_comb begin
    memWriteData = mBigEndian ? byteSwap(leData) : leData;
    for (int i = 0; i < XBYTES; i++) begin
      // Mirror lane enables to follow the swapped data
      memByteMask[i] = mBigEndian ? leMask[XBYTES-1-i] : leMask[i];
    end
  end

endmodule

`default_nettype wire

/* sim/lsuModel.svh */
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model of the load/store unit
////////////////////////////////////////////////////////////

typedef struct packed {
  logic [XLEN-1:0] data;      // Extended load value, zero for stores
  logic            loadMis;
  logic            storeMis;
  logic            scFail;
} respT;

logic [7:0] shadowMem [2**DTIM_ADDR_BITS];  // Byte image of the DTIM
bit         shadowResValid;                  // Reservation copy
int         shadowResWord;

// Memory lane of byte k for an access at byte offset offs
function automatic int laneOf(input int offs, input int k, input logic bigEndian);
  return bigEndian ? 3 - (offs + k) : offs + k;  // Big-endian mirrors the lanes
endfunction

// Expected response of one request, updates the shadow state
function automatic respT lsuExpect(input memOpT op, input sizeT size,
    input logic [XLEN-1:0] adr, input logic [XLEN-1:0] wdata, input logic bigEndian);
  respT r;
  int   byteAdr;
  int   offs;
  int   base;
  int   nBytes;
  bit   isLoad;
  bit   doWrite;
  r       = '0;
  byteAdr = int'(adr[DTIM_ADDR_BITS-1:0]);   // Upper address bits ignored
  offs    = byteAdr % 4;
  base    = byteAdr - offs;
  nBytes  = (size == sizeWord) ? 4 : (size == sizeHalf || size == sizeHalfU) ? 2 : 1;
  isLoad  = (op == opLoad) || (op == opLr);
  // Natural alignment required, nothing else changes on a fault
  if (offs % nBytes != 0) begin
    r.loadMis  = isLoad;
    r.storeMis = !isLoad;
    r.scFail   = (op == opSc);
    return r;
  end
  if (isLoad) begin
    for (int k = 0; k < nBytes; k++) begin
      r.data[8*k +: 8] = shadowMem[base + laneOf(offs, k, bigEndian)];
    end
    if (size == sizeByte) r.data = {{(XLEN-8){r.data[7]}}, r.data[7:0]};
    if (size == sizeHalf) r.data = {{(XLEN-16){r.data[15]}}, r.data[15:0]};
    if (op == opLr) begin
      shadowResValid = 1'b1;
      shadowResWord  = base / 4;
    end
  end else begin
    doWrite = (op == opStore) || (shadowResValid && shadowResWord == base / 4);
    if (op == opSc) begin
      r.scFail       = !doWrite;
      shadowResValid = 1'b0;                 // Any SC drops the reservation
    end
    if (doWrite) begin
      for (int k = 0; k < nBytes; k++) begin
        shadowMem[base + laneOf(offs, k, bigEndian)] = wdata[8*k +: 8];
      end
    end
  end
  return r;
endfunction

`endif

/* sim/lsuTb.sv */
`default_nettype none
`timescale 1ns/1ns

module lsuTb import lsuPkg::*; ();

  localparam int DTIM_ADDR_BITS = 10;
  localparam int N_FILL     = 2 ** (DTIM_ADDR_BITS - 2);  // One store per word
  localparam int N_DIRECTED = 4*14 + 2*17 + 20 + 15;
  localparam int N_RANDOM   = 300;
  localparam int MAX_REQS   = N_FILL + N_DIRECTED + 2*N_RANDOM;
  localparam int TIMEOUT    = 4*MAX_REQS + 200;
  localparam logic [XLEN-1:0] WORDS1 [4] = '{32'h80FF_7F01, 32'h7F80_01FE,
                                             32'hDEAD_BEEF, 32'h0123_4567};
  localparam sizeT SIZES [5] = '{sizeByte, sizeHalf, sizeWord, sizeByteU, sizeHalfU};

  logic            clk, reset;
  logic            reqValid, reqReady, reqBigEndian;
  memOpT           reqOp;
  sizeT            reqSize;
  logic [XLEN-1:0] reqAdr, reqWriteData, respReadData;
  logic            respValid, respReady;
  logic            respLoadMisaligned, respStoreMisaligned, respScFail;

  `include "lsuModel.svh"

  respT expQ[$];       // Expectations in request order
  int   reqCount, respCount, cycleCount;
  bit   randomReady;   // Random back-pressure on the response port

  lsu #(.DTIM_ADDR_BITS(DTIM_ADDR_BITS)) dut_i (
    .clk, .reset, .reqValid, .reqReady, .reqOp, .reqSize, .reqAdr, .reqWriteData,
    .reqBigEndian, .respValid, .respReady, .respReadData, .respLoadMisaligned,
    .respStoreMisaligned, .respScFail
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // Watchdog and checker
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT) begin
      $display("Timeout after %0d cycles, no response arrived for %0d pending requests",
               cycleCount, expQ.size());
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
    end
  end

  task automatic checkEqual(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Response mismatch");
    end
  endtask

  // Pop one expectation per response transfer
  always @(posedge clk) begin
    respT e;
    if (!reset && respValid && respReady) begin
      if (expQ.size() == 0) begin
        $display("Response %0d arrived with no request outstanding", respCount);
        $display("Simulation failed");
        $fatal(1, "Extra response");
      end else begin
        e = expQ.pop_front();
        checkEqual(respReadData, e.data, $sformatf("resp %0d read data", respCount));
        checkEqual(respLoadMisaligned, e.loadMis, $sformatf("resp %0d load fault", respCount));
        checkEqual(respStoreMisaligned, e.storeMis,
                   $sformatf("resp %0d store fault", respCount));
        checkEqual(respScFail, e.scFail, $sformatf("resp %0d SC fail", respCount));
        respCount++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers called right after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic driveReady();
    respReady <= !randomReady || ($urandom % 2 == 0);
  endtask

  task automatic sendReq(input memOpT op, input sizeT size, input logic [XLEN-1:0] adr,
                         input logic [XLEN-1:0] wdata, input logic be);
    reqValid     <= 1'b1;
    reqOp        <= op;
    reqSize      <= size;
    reqAdr       <= adr;
    reqWriteData <= wdata;
    reqBigEndian <= be;
    driveReady();
    @(posedge clk);
    while (!reqReady) begin   // Inputs held until accepted
      driveReady();
      @(posedge clk);
    end
    expQ.push_back(lsuExpect(op, size, adr, wdata, be));
    reqCount++;
  endtask

  task automatic idle(input int n);
    reqValid <= 1'b0;
    repeat (n) begin
      driveReady();
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] a2;
    memOpT           op;
    sizeT            sz;
    logic            be;
    void'($urandom(93945));
    reset <= 1'b1;
    reqValid <= 1'b0;
    reqOp <= opLoad;
    reqSize <= sizeWord;
    reqAdr <= '0;
    reqWriteData <= '0;
    reqBigEndian <= 1'b0;
    respReady <= 1'b1;
    randomReady = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // Fill every word with a pattern hashed from the address
    for (int a = 0; a < N_FILL; a++) begin
      sendReq(opStore, sizeWord, 4*a, (a * 32'h9E37_79B1) ^ 32'h6C8E_9CF5, 1'b0);
    end
    // Loads of every size at every aligned offset with junk upper bits
    for (int i = 0; i < 4; i++) begin
      adr = 32'h1234_5040 + 4*i;
      sendReq(opStore, sizeWord, adr, WORDS1[i], 1'b0);
      for (int o = 0; o < 4; o++) begin
        sendReq(opLoad, sizeByte, adr + o, '0, 1'b0);
        sendReq(opLoad, sizeByteU, adr + o, '0, 1'b0);
      end
      for (int o = 0; o < 4; o += 2) begin
        sendReq(opLoad, sizeHalf, adr + o, '0, 1'b0);
        sendReq(opLoad, sizeHalfU, adr + o, '0, 1'b0);
      end
      sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    end
    // Subword stores in little then big endian
    for (int m = 0; m < 2; m++) begin
      be  = m[0];
      adr = 32'h80 + 8*m;
      sendReq(opStore, sizeWord, adr, 32'h1122_3344, 1'b0);
      for (int o = 0; o < 4; o++) begin
        sendReq(opStore, sizeByte, adr + o, 32'hC3C3_C3A0 + o, be);
        sendReq(opLoad, sizeWord, adr, '0, be);
      end
      for (int o = 0; o < 4; o += 2) begin
        sendReq(opStore, sizeHalf, adr + o, 32'h5A5A_B700 + o, be);
        sendReq(opLoad, sizeWord, adr, '0, be);
      end
      for (int o = 0; o < 4; o++) sendReq(opLoad, sizeByteU, adr + o, '0, be);
    end
    // Misaligned accesses leave memory alone
    adr = 32'hC0;
    for (int o = 1; o < 4; o++) begin
      sendReq(opStore, sizeWord, adr + o, 32'hDEAD_BEEF, 1'b0);
      sendReq(opLoad, sizeWord, adr, '0, 1'b0);
      sendReq(opLoad, sizeWord, adr + o, '0, 1'b0);
    end
    for (int o = 1; o < 4; o += 2) begin
      sendReq(opStore, sizeHalf, adr + o, 32'hBEEF, o == 3);
      sendReq(opLoad, sizeWord, adr, '0, 1'b0);
      sendReq(opLoad, sizeHalf, adr + o, '0, 1'b0);
      sendReq(opLoad, sizeHalfU, adr + o, '0, 1'b0);
    end
    sendReq(opLr, sizeWord, adr + 2, '0, 1'b0);
    sendReq(opSc, sizeWord, adr + 1, 32'h1, 1'b0);
    sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    // LR/SC pairs on the neighbouring words adr and a2
    adr = 32'h100;
    a2  = 32'h104;
    sendReq(opSc, sizeWord, adr, 32'h1111_1111, 1'b0);   // No reservation yet
    sendReq(opLr, sizeWord, adr, '0, 1'b0);
    sendReq(opSc, sizeWord, adr, 32'h2222_2222, 1'b0);
    sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    sendReq(opSc, sizeWord, adr, 32'h3333_3333, 1'b0);   // Second SC
    sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    sendReq(opLr, sizeWord, adr, '0, 1'b0);
    sendReq(opSc, sizeWord, a2, 32'h4444_4444, 1'b0);    // Other word
    sendReq(opLoad, sizeWord, a2, '0, 1'b0);
    sendReq(opSc, sizeWord, adr, 32'h4545_4545, 1'b0);
    sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    sendReq(opLr, sizeWord, adr, '0, 1'b0);
    sendReq(opStore, sizeByte, adr + 1, 32'h77, 1'b0);   // Plain store keeps reservation
    sendReq(opSc, sizeWord, adr, 32'h5555_5555, 1'b0);
    sendReq(opLoad, sizeWord, adr, '0, 1'b0);
    // Random stream with response back-pressure
    randomReady = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      adr = ($urandom & 32'hFFFF_FC00) | $urandom_range(0, 63);
      op  = memOpT'($urandom_range(0, 3));
      sz  = SIZES[$urandom_range(0, 4)];
      be  = ($urandom % 4 == 0);
      sendReq(op, sz, adr, $urandom, be);
      if (op == opStore && $urandom % 2 == 0) sendReq(opLoad, sz, adr, '0, be);
      if ($urandom % 8 == 0) idle(1);
    end
    randomReady = 1'b0;
    idle(1);
    while (expQ.size() != 0) @(posedge clk);
    repeat (8) @(posedge clk);   // Window for a stray response
    if (reqCount == respCount) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+sim
hdl/lsuPkg.sv
hdl/reservation.sv
hdl/storeFormat.sv
hdl/loadFormat.sv
hdl/dtim.sv
hdl/lsuPipeline.sv
hdl/lsu.sv
sim/lsuTb.sv
